// File: logic/emesh_pkg.sv
package emesh_pkg;

   // Mesh widths
   localparam int AW = 32;
   localparam int DW = AW;
   localparam int PW = 2 * AW + 40;

   // Packet field positions
   localparam int WRITE_BIT = 0;
   localparam int DM_LSB    = 1;
   localparam int DM_MSB    = 2;
   localparam int CM_LSB    = 3;
   localparam int CM_MSB    = 7;
   localparam int DST_LSB   = 8;
   localparam int DST_MSB   = DST_LSB + AW - 1;
   localparam int DATA_LSB  = DST_MSB + 1;
   localparam int DATA_MSB  = DATA_LSB + DW - 1;
   localparam int SRC_LSB   = DATA_MSB + 1;
   localparam int SRC_MSB   = SRC_LSB + AW - 1;

   // Scratch array, 64-bit doublewords
   localparam int MEM_DEPTH = 256;
   localparam int MAW       = $clog2(MEM_DEPTH);

   typedef logic [PW-1:0]     packet_t;
   typedef logic [AW-1:0]     addr_t;
   typedef logic [DW-1:0]     data_t;
   typedef logic [1:0]        datamode_t;
   typedef logic [4:0]        ctrlmode_t;
   typedef logic [MAW-1:0]    mem_index_t;
   typedef logic [63:0]       mem_word_t;
   typedef logic [7:0]        byte_mask_t;

   // Transfer sizes
   localparam datamode_t DM_BYTE   = 2'd0;
   localparam datamode_t DM_SHORT  = 2'd1;
   localparam datamode_t DM_WORD   = 2'd2;
   localparam datamode_t DM_DOUBLE = 2'd3;

endpackage

// File: logic/packet_decode.sv
`timescale 1ns/1ns

module packet_decode
(
   input  emesh_pkg::packet_t   packet_in,
   output logic                 write,
   output emesh_pkg::datamode_t datamode,
   output emesh_pkg::ctrlmode_t ctrlmode,
   output emesh_pkg::addr_t     dstaddr,
   output emesh_pkg::data_t     data,
   output emesh_pkg::addr_t     srcaddr
);

   import emesh_pkg::*;

   // Request fields, low to high
   assign write    = packet_in[WRITE_BIT];
   assign datamode = packet_in[DM_MSB:DM_LSB];
   assign ctrlmode = packet_in[CM_MSB:CM_LSB];
   assign dstaddr  = packet_in[DST_MSB:DST_LSB];
   assign data     = packet_in[DATA_MSB:DATA_LSB];

   // Return address of the requester
   assign srcaddr  = packet_in[SRC_MSB:SRC_LSB];

endmodule

// File: logic/write_format.sv
`timescale 1ns/1ns

module write_format
(
   input  logic                  write,
   input  emesh_pkg::datamode_t  datamode,
   input  logic [2:0]            dstaddr_low,
   input  emesh_pkg::data_t      data,
   input  emesh_pkg::addr_t      srcaddr,
   output emesh_pkg::mem_word_t  din,
   output emesh_pkg::byte_mask_t byte_mask
);

   import emesh_pkg::*;

   byte_mask_t size_mask;

   // Copy the data into every lane it could land in
   always_comb
   begin
      case (datamode)
         DM_BYTE:
         begin
            din = {8{data[7:0]}};
         end
         DM_SHORT:
         begin
            din = {4{data[15:0]}};
         end
         DM_WORD:
         begin
            din = {2{data}};
         end
         default:
         begin
            // Double carries its high word in the source field
            din = {srcaddr, data};
         end
      endcase
   end

   // Bytes touched by this size at this offset
   always_comb
   begin
      case (datamode)
         DM_BYTE:
         begin
            size_mask = 8'b0000_0001 << dstaddr_low;
         end
         DM_SHORT:
         begin
            size_mask = 8'b0000_0011 << {dstaddr_low[2:1], 1'b0};
         end
         DM_WORD:
         begin
            size_mask = dstaddr_low[2] ? 8'b1111_0000 : 8'b0000_1111;
         end
         default:
         begin
            size_mask = 8'b1111_1111;
         end
      endcase
   end

   // Reads never touch the array
   assign byte_mask = write ? size_mask : '0;

endmodule

// File: logic/sp_memory.sv
`timescale 1ns/1ns

module sp_memory
(
   input  logic                  clk,
   input  logic                  en,
   input  logic                  we,
   input  emesh_pkg::byte_mask_t byte_mask,
   input  emesh_pkg::mem_index_t addr,
   input  emesh_pkg::mem_word_t  din,
   output emesh_pkg::mem_word_t  dout
);

   import emesh_pkg::*;

   mem_word_t mem [MEM_DEPTH];

   always_ff @(posedge clk)
   begin
      if (en && we)
      begin
         // Only the enabled bytes change
         for (int i = 0; i < 8; i++)
         begin
            if (byte_mask[i])
            begin
               mem[addr][8*i +: 8] <= din[8*i +: 8];
            end
         end
      end
      else if (en)
      begin
         dout <= mem[addr];
      end
   end

endmodule

// File: logic/read_align.sv
`timescale 1ns/1ns

module read_align
(
   input  emesh_pkg::datamode_t datamode,
   input  logic [2:0]           addr_low,
   input  emesh_pkg::mem_word_t dout,
   output emesh_pkg::data_t     data
);

   import emesh_pkg::*;

   always_comb
   begin
      case (datamode)
         DM_BYTE:
         begin
            data = {24'd0, dout[8*addr_low +: 8]};
         end
         DM_SHORT:
         begin
            data = {16'd0, dout[16*addr_low[2:1] +: 16]};
         end
         DM_WORD:
         begin
            // Bit 2 picks the half
            data = addr_low[2] ? dout[63:32] : dout[31:0];
         end
         default:
         begin
            // High word of a double goes out in the source field
            data = dout[31:0];
         end
      endcase
   end

endmodule

// File: logic/packet_encode.sv
`timescale 1ns/1ns

module packet_encode
(
   input  logic                 write,
   input  emesh_pkg::datamode_t datamode,
   input  emesh_pkg::ctrlmode_t ctrlmode,
   input  emesh_pkg::addr_t     dstaddr,
   input  emesh_pkg::data_t     data,
   input  emesh_pkg::addr_t     srcaddr,
   output emesh_pkg::packet_t   packet_out
);

   import emesh_pkg::*;

   // Same layout as the request side
   assign packet_out[WRITE_BIT]         = write;
   assign packet_out[DM_MSB:DM_LSB]     = datamode;
   assign packet_out[CM_MSB:CM_LSB]     = ctrlmode;
   assign packet_out[DST_MSB:DST_LSB]   = dstaddr;
   assign packet_out[DATA_MSB:DATA_LSB] = data;
   assign packet_out[SRC_MSB:SRC_LSB]   = srcaddr;

endmodule

// File: logic/emesh_memory.sv
`timescale 1ns/1ns

module emesh_memory
(
   input  logic               clk,
   input  logic               nreset,
   input  logic               access_in,
   input  emesh_pkg::packet_t packet_in,
   output logic               wait_out,
   output logic               access_out,
   output emesh_pkg::packet_t packet_out,
   input  logic               wait_in
);

   import emesh_pkg::*;

   // Request fields
   logic       write_in;
   datamode_t  datamode_in;
   ctrlmode_t  ctrlmode_in;
   addr_t      dstaddr_in;
   data_t      data_in;
   addr_t      srcaddr_in;

   // Array side
   logic       en;
   logic       mem_rd;
   mem_index_t mem_index;
   mem_word_t  din;
   mem_word_t  dout;
   byte_mask_t byte_mask;

   // Response register
   datamode_t  datamode_q;
   ctrlmode_t  ctrlmode_q;
   logic [2:0] addr_low_q;
   addr_t      dstaddr_q;
   data_t      data_out;
   addr_t      srcaddr_out;

   packet_decode i_packet_decode (
      .packet_in (packet_in),
      .write     (write_in),
      .datamode  (datamode_in),
      .ctrlmode  (ctrlmode_in),
      .dstaddr   (dstaddr_in),
      .data      (data_in),
      .srcaddr   (srcaddr_in)
   );

   // Mesh back-pressure goes straight to the requester
   assign wait_out = wait_in;

   assign en        = access_in & ~wait_in;
   assign mem_rd    = en & ~write_in;
   assign mem_index = dstaddr_in[MAW+2:3];

   write_format i_write_format (
      .write       (write_in),
      .datamode    (datamode_in),
      .dstaddr_low (dstaddr_in[2:0]),
      .data        (data_in),
      .srcaddr     (srcaddr_in),
      .din         (din),
      .byte_mask   (byte_mask)
   );

   sp_memory i_sp_memory (
      .clk       (clk),
      .en        (en),
      .we        (write_in),
      .byte_mask (byte_mask),
      .addr      (mem_index),
      .din       (din),
      .dout      (dout)
   );

   // Valid flag, frozen while the mesh is stalled
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         access_out <= 1'b0;
      end
      else if (!wait_in)
      begin
         access_out <= mem_rd;
      end
   end

   // Response fields travel alongside the array read
   always_ff @(posedge clk)
   begin
      if (!wait_in)
      begin
         datamode_q <= datamode_in;
         ctrlmode_q <= ctrlmode_in;
         addr_low_q <= dstaddr_in[2:0];
         dstaddr_q  <= srcaddr_in;
      end
   end

   read_align i_read_align (
      .datamode (datamode_q),
      .addr_low (addr_low_q),
      .dout     (dout),
      .data     (data_out)
   );

   // Double reads return their high word here
   assign srcaddr_out = (datamode_q == DM_DOUBLE) ? dout[63:32] : '0;

   packet_encode i_packet_encode (
      .write      (1'b1),
      .datamode   (datamode_q),
      .ctrlmode   (ctrlmode_q),
      .dstaddr    (dstaddr_q),
      .data       (data_out),
      .srcaddr    (srcaddr_out),
      .packet_out (packet_out)
   );

endmodule

// File: verification/emesh_memory_assertions.sv
`timescale 1ns/1ns

module emesh_memory_assertions
(
   input logic               clk,
   input logic               nreset,
   input logic               access_in,
   input emesh_pkg::packet_t packet_in,
   input logic               wait_out,
   input logic               access_out,
   input emesh_pkg::packet_t packet_out,
   input logic               wait_in
);

   import emesh_pkg::*;

   a_reset_idle: assert property (@(posedge clk) !nreset |-> !access_out)
      else $error("access_out high during reset");

   // Back-pressure is a straight wire
   a_wait_pass: assert property (@(posedge clk) wait_out == wait_in)
      else $error("wait_out does not follow wait_in");

   a_hold: assert property (@(posedge clk) disable iff (!nreset)
                            access_out && wait_in |=> access_out && $stable(packet_out))
      else $error("response not held under wait_in");

   // A fresh response needs a read accepted on the edge before
   a_cause: assert property (@(posedge clk) disable iff (!nreset)
                             access_out && !$past(wait_in)
                             |-> $past(access_in && !wait_in && !packet_in[WRITE_BIT]))
      else $error("response without an accepted read");

endmodule

bind emesh_memory emesh_memory_assertions i_emesh_memory_assertions (
   .clk        (clk),
   .nreset     (nreset),
   .access_in  (access_in),
   .packet_in  (packet_in),
   .wait_out   (wait_out),
   .access_out (access_out),
   .packet_out (packet_out),
   .wait_in    (wait_in)
);

// File: verification/tb_emesh_memory.sv
`timescale 1ns/1ns

module tb_emesh_memory;

   import emesh_pkg::*;

   localparam int CLK_PERIOD     = 10;
   localparam int N_FILL         = MEM_DEPTH;
   localparam int N_DOUBLES      = 16;
   localparam int N_MASK_ROUNDS  = 4;
   localparam int MASK_ROUND_LEN = 19;
   localparam int N_BP_READS     = 100;
   localparam int N_RANDOM       = 400;
   localparam int TOTAL_REQUESTS = N_FILL + 2 * N_DOUBLES + N_MASK_ROUNDS * MASK_ROUND_LEN
                                   + N_BP_READS + N_RANDOM;
   localparam int TIMEOUT_CYCLES = TOTAL_REQUESTS * 20 + 200;

   logic    clk = 1'b0;
   logic    nreset;
   logic    access_in;
   packet_t packet_in;
   logic    wait_out;
   logic    access_out;
   packet_t packet_out;
   logic    wait_in = 1'b0;

   // Reference array, one entry per byte
   logic [7:0] ref_mem [MEM_DEPTH*8];
   packet_t    pending_q [$];
   packet_t    expected;
   packet_t    held_packet;
   logic       held_valid = 1'b0;
   int         bp_percent = 0;
   int         read_count = 0;
   int         checked_count = 0;

   always #(CLK_PERIOD/2) clk = ~clk;

   emesh_memory i_emesh_memory (
      .clk        (clk),
      .nreset     (nreset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in)
   );

   function automatic packet_t build_packet(input logic write, input datamode_t dm,
                                            input ctrlmode_t cm, input addr_t dst,
                                            input data_t data, input addr_t src);
      return {src, data, dst, cm, dm, write};
   endfunction

   function automatic addr_t align_addr(input datamode_t dm, input addr_t raw);
      return raw & ~((addr_t'(1) << dm) - addr_t'(1));
   endfunction

   // Random upper bits alias onto the same doubleword
   function automatic addr_t make_addr(input mem_index_t idx, input logic [2:0] offset);
      return {21'($urandom), idx, offset};
   endfunction

   function automatic void apply_write(input packet_t req);
      datamode_t   dm;
      addr_t       dst;
      logic [63:0] value;
      logic [10:0] base;
      int          nbytes;
      int          k;
      dm = req[DM_MSB:DM_LSB];
      dst = req[DST_MSB:DST_LSB];
      nbytes = 1 << dm;
      // Source field is the high word of a double
      value = {req[SRC_MSB:SRC_LSB], req[DATA_MSB:DATA_LSB]};
      base = dst[10:0] & ~11'(nbytes - 1);
      for (k = 0; k < nbytes; k++)
      begin
         ref_mem[base + 11'(k)] = value[8*k +: 8];
      end
   endfunction

   function automatic packet_t expected_response(input packet_t req);
      datamode_t   dm;
      addr_t       dst;
      addr_t       high;
      logic [63:0] value;
      logic [10:0] base;
      int          nbytes;
      int          k;
      dm = req[DM_MSB:DM_LSB];
      dst = req[DST_MSB:DST_LSB];
      nbytes = 1 << dm;
      base = dst[10:0] & ~11'(nbytes - 1);
      value = '0;
      for (k = 0; k < nbytes; k++)
      begin
         value[8*k +: 8] = ref_mem[base + 11'(k)];
      end
      high = (dm == DM_DOUBLE) ? value[63:32] : '0;
      // Reply goes back to the requester
      return build_packet(1'b1, dm, req[CM_MSB:CM_LSB], req[SRC_MSB:SRC_LSB],
                          value[31:0], high);
   endfunction

   task automatic check_packet(input packet_t actual, input packet_t exp, input string what);
      if (actual !== exp)
      begin
         $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, actual, exp);
         $display("Test failures found");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic check_access(input logic actual, input logic exp, input string what);
      if (actual !== exp)
      begin
         $display("** Error at %0t ns: %s, got %b, expected %b", $time, what, actual, exp);
         $display("Test failures found");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   // Called on a falling edge, returns on the falling edge after acceptance
   task automatic send_request(input logic write, input datamode_t dm, input addr_t dst,
                               input data_t data, input addr_t src);
      ctrlmode_t cm;
      cm = ctrlmode_t'($urandom_range(31));
      access_in = 1'b1;
      packet_in = build_packet(write, dm, cm, dst, data, src);
      @(posedge clk);
      while (wait_out)
      begin
         @(posedge clk);
      end
      if (!write)
      begin
         read_count++;
      end
      @(negedge clk);
      access_in = 1'b0;
   endtask

   task automatic fill_memory();
      mem_index_t idx;
      int         i;
      for (i = 0; i < N_FILL; i++)
      begin
         idx = mem_index_t'(i);
         send_request(1'b1, DM_DOUBLE, {21'd0, idx, 3'd0},
                      {idx, ~idx, idx ^ 8'h3c, 8'h96}, {idx ^ 8'ha5, 8'h0f, ~idx, idx});
      end
   endtask

   task automatic double_test();
      mem_index_t idx;
      int         i;
      for (i = 0; i < N_DOUBLES; i++)
      begin
         idx = mem_index_t'(i * 37 + 11);
         send_request(1'b1, DM_DOUBLE, make_addr(idx, 3'd0), $urandom, $urandom);
      end
      for (i = 0; i < N_DOUBLES; i++)
      begin
         idx = mem_index_t'(i * 37 + 11);
         send_request(1'b0, DM_DOUBLE, make_addr(idx, 3'd0), $urandom, $urandom);
      end
   endtask

   // Partial writes into a known doubleword, then every read position
   task automatic mask_test();
      mem_index_t idx;
      int         k;
      int         j;
      for (k = 0; k < N_MASK_ROUNDS; k++)
      begin
         idx = mem_index_t'(40 + k * 53);
         send_request(1'b1, DM_DOUBLE, make_addr(idx, 3'd0), 32'h33221100 + k, 32'h77665544);
         send_request(1'b1, DM_BYTE, make_addr(idx, 3'(k)), $urandom, $urandom);
         send_request(1'b1, DM_BYTE, make_addr(idx, 3'(7 - k)), $urandom, $urandom);
         send_request(1'b1, DM_SHORT, make_addr(idx, 3'(2 * ((k + 1) % 4))), $urandom, $urandom);
         for (j = 0; j < 8; j++)
         begin
            send_request(1'b0, DM_BYTE, make_addr(idx, 3'(j)), $urandom, $urandom);
         end
         for (j = 0; j < 4; j++)
         begin
            send_request(1'b0, DM_SHORT, make_addr(idx, 3'(2 * j)), $urandom, $urandom);
         end
         for (j = 0; j < 2; j++)
         begin
            send_request(1'b0, DM_WORD, make_addr(idx, 3'(4 * j)), $urandom, $urandom);
         end
         send_request(1'b0, DM_DOUBLE, make_addr(idx, 3'd0), $urandom, $urandom);
      end
   endtask

   task automatic backpressure_test();
      datamode_t dm;
      int        i;
      bp_percent = 30;
      for (i = 0; i < N_BP_READS; i++)
      begin
         dm = datamode_t'($urandom_range(3));
         send_request(1'b0, dm, align_addr(dm, $urandom), $urandom, $urandom);
      end
   endtask

   task automatic random_test();
      datamode_t dm;
      logic      write;
      int        i;
      bp_percent = 10;
      for (i = 0; i < N_RANDOM; i++)
      begin
         dm = datamode_t'($urandom_range(3));
         write = 1'($urandom_range(1));
         send_request(write, dm, align_addr(dm, $urandom), $urandom, $urandom);
      end
   endtask

   // Mesh stalls, drawn on the falling edge
   always @(negedge clk)
   begin
      wait_in = (bp_percent != 0) && ($urandom_range(99) < bp_percent);
   end

   // Reference model and response compare
   always @(posedge clk)
   begin
      if (nreset)
      begin
         check_access(wait_out, wait_in, "wait_out");
         check_access(access_out, pending_q.size() != 0, "access_out");
         if (held_valid)
         begin
            check_packet(packet_out, held_packet, "response changed while stalled");
         end
         held_valid = 1'b0;
         if (access_out && !wait_in)
         begin
            expected = pending_q.pop_front();
            check_packet(packet_out, expected, "read response");
            checked_count++;
         end
         else if (access_out && wait_in)
         begin
            held_valid = 1'b1;
            held_packet = packet_out;
         end
         if (access_in && !wait_out)
         begin
            if (packet_in[WRITE_BIT])
            begin
               apply_write(packet_in);
            end
            else
            begin
               pending_q.push_back(expected_response(packet_in));
            end
         end
      end
   end

   initial
   begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("Test failures found");
      $fatal(1, "watchdog expired");
   end

   initial
   begin
      void'($urandom(51));
      nreset = 1'b0;
      access_in = 1'b0;
      packet_in = '0;
      repeat (10) @(negedge clk);
      nreset = 1'b1;
      // Idle cycles, access_out must stay low
      repeat (4) @(negedge clk);
      fill_memory();
      double_test();
      mask_test();
      backpressure_test();
      random_test();
      bp_percent = 0;
      while (pending_q.size() != 0)
      begin
         @(negedge clk);
      end
      repeat (4) @(negedge clk);
      $display("%0d reads issued, %0d responses checked", read_count, checked_count);
      if (read_count == checked_count)
      begin
         $display("All tests passed!");
         $finish;
      end
      else
      begin
         $display("Response count differs from the number of accepted reads");
         $display("Test failures found");
         $fatal(1, "response count mismatch");
      end
   end

endmodule

// File: filelist.f
logic/emesh_pkg.sv
logic/packet_decode.sv
logic/write_format.sv
logic/sp_memory.sv
logic/read_align.sv
logic/packet_encode.sv
logic/emesh_memory.sv
verification/emesh_memory_assertions.sv
verification/tb_emesh_memory.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the emesh memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
PASS_TEXT="All tests passed!"

verilator --binary --timing --assert \
   --timescale 1ns/1ns \
   --top-module tb_emesh_memory \
   -Mdir "$BUILD_DIR" -o sim \
   -f filelist.f
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "ERROR: Verilator build failed with status $build_status"
   exit 1
fi

"./$BUILD_DIR/sim" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
   echo "ERROR: simulation exited with status $sim_status"
   exit 1
fi

if grep -q "$PASS_TEXT" "$LOG_FILE"; then
   echo "RESULT: PASS"
   exit 0
else
   echo "RESULT: FAIL"
   exit 1
fi
